// ==== baud_tick_gen.sv ====
`default_nettype none

module baud_tick_gen #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic clk,
	input  logic reset,
	input  logic baud_restart,
	output logic baud_tick
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	typedef logic [CNT_W-1:0] baud_count_t;

	localparam baud_count_t LAST_COUNT = baud_count_t'(CLKS_PER_BIT - 1);

	baud_count_t count;

	// Down-counter, restart lines bit edges up with the start bit
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			count <= LAST_COUNT;
		else if (baud_restart || count == '0)
			count <= LAST_COUNT;
		else
			count <= count - 1'b1;
	end

	// Last clock of each bit period
	assign baud_tick = (count == '0);

endmodule

`default_nettype wire

// ==== result_pkg.sv ====
`default_nettype none

package result_pkg;

	// One result as produced upstream
	typedef logic [31:0] result_word_t;

	// Characters sent per result, MSB byte first
	localparam int RESULT_BYTES = 4;

	typedef logic [$clog2(RESULT_BYTES+1)-1:0] byte_count_t;

	// ASCII '0', so 0..9 show up as digits on the host
	localparam logic [7:0] ASCII_DIGIT_OFFSET = 8'd48;

	////////////////////////////////////////
	// Framer FSM
	////////////////////////////////////////

	typedef enum logic [1:0] {
		fr_idle,
		fr_send_first,
		fr_wait_done
	} framer_state_t;

endpackage

`default_nettype wire

// ==== result_tx_framer.sv ====
`default_nettype none

module result_tx_framer import uart_pkg::*, result_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  result_word_t in_data,
	input  logic         new_result,
	input  logic         tx_done,
	output uart_byte_t   tx_byte,
	output logic         tx_start,
	output logic         data_done,
	output logic         busy
);

	localparam int WORD_W = $bits(result_word_t);
	localparam int BYTE_W = $bits(uart_byte_t);

	framer_state_t state;
	result_word_t  word_sr;
	byte_count_t   byte_cnt;

	// Top byte of the word, shifted into the printable range
	function automatic uart_byte_t offset_byte(input result_word_t word);
		uart_byte_t top;
		top = word[WORD_W-1 -: BYTE_W];
		return top + ASCII_DIGIT_OFFSET;
	endfunction

	////////////////////////////////////////
	// Framer FSM
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= fr_idle;
			byte_cnt  <= '0;
			tx_start  <= 1'b0;
			data_done <= 1'b0;
			busy      <= 1'b0;
		end
		else
		begin
			// Single-cycle strobes by default
			tx_start  <= 1'b0;
			data_done <= 1'b0;
			case (state)
				fr_idle:
				begin
					if (new_result)
					begin
						byte_cnt <= byte_count_t'(RESULT_BYTES);
						busy     <= 1'b1;
						state    <= fr_send_first;
					end
				end
				fr_send_first:
				begin
					byte_cnt <= byte_cnt - 1'b1;
					tx_start <= 1'b1;
					state    <= fr_wait_done;
				end
				fr_wait_done:
				begin
					if (tx_done)
					begin
						if (byte_cnt == '0)
						begin
							// Last stop bit is out
							data_done <= 1'b1;
							busy      <= 1'b0;
							state     <= fr_idle;
						end
						else
						begin
							byte_cnt <= byte_cnt - 1'b1;
							tx_start <= 1'b1;
						end
					end
				end
				default:
					state <= fr_idle;
			endcase
		end
	end

	////////////////////////////////////////
	// Word and character registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == fr_idle && new_result)
			word_sr <= in_data;
		else if (state == fr_send_first ||
			(state == fr_wait_done && tx_done && byte_cnt != '0))
		begin
			tx_byte <= offset_byte(word_sr);
			word_sr <= word_sr << BYTE_W;
		end
	end

endmodule

`default_nettype wire

// ==== result_tx_top.f ====
uart_pkg.sv
result_pkg.sv
baud_tick_gen.sv
uart_tx.sv
result_tx_framer.sv
result_tx_top.sv
tb_result_tx_top.sv

// ==== result_tx_top.sv ====
`default_nettype none

module result_tx_top import uart_pkg::*, result_pkg::*; #(
	parameter int CLKS_PER_BIT = DEFAULT_CLKS_PER_BIT
) (
	input  logic         clk,
	input  logic         reset,
	input  result_word_t in_data,
	input  logic         new_result,
	output logic         serial_out,
	output logic         busy,
	output logic         data_done
);

	////////////////////////////////////////
	// Internal strobes
	////////////////////////////////////////

	uart_byte_t tx_byte;
	logic       tx_start;
	logic       tx_done;
	logic       baud_restart;
	logic       baud_tick;

	// Word to characters
	result_tx_framer framer_i (
		.clk        (clk),
		.reset      (reset),
		.in_data    (in_data),
		.new_result (new_result),
		.tx_done    (tx_done),
		.tx_byte    (tx_byte),
		.tx_start   (tx_start),
		.data_done  (data_done),
		.busy       (busy)
	);

	// Characters to the line
	uart_tx uart_tx_i (
		.clk          (clk),
		.reset        (reset),
		.tx_start     (tx_start),
		.tx_byte      (tx_byte),
		.baud_tick    (baud_tick),
		.serial_out   (serial_out),
		.baud_restart (baud_restart),
		.tx_done      (tx_done)
	);

	// Bit timing
	baud_tick_gen #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) baud_i (
		.clk          (clk),
		.reset        (reset),
		.baud_restart (baud_restart),
		.baud_tick    (baud_tick)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_result_tx_top \
	-f result_tx_top.f -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

// ==== tb_result_tx_top.sv ====
`default_nettype none

module tb_result_tx_top import uart_pkg::*, result_pkg::*; ();

	localparam int CLKS_PER_BIT  = 4;
	localparam int NUM_WORDS     = 40;
	localparam int DONE_TIMEOUT  = 400;
	localparam int BYTE_W        = $bits(uart_byte_t);

	logic         clk;
	logic         reset;
	result_word_t in_data;
	logic         new_result;
	logic         serial_out;
	logic         busy;
	logic         data_done;

	logic [31:0]  lfsr_state;
	uart_byte_t   rx_q[$];
	uart_byte_t   exp_q[$];
	uart_byte_t   last_rx[RESULT_BYTES];

	result_tx_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) dut_i (
		.clk        (clk),
		.reset      (reset),
		.in_data    (in_data),
		.new_result (new_result),
		.serial_out (serial_out),
		.busy       (busy),
		.data_done  (data_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Random numbers and failure reporting
	////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic stop_with_failure();
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t got);
		if (got !== exp)
		begin
			$display("Mismatch at time %0t: %s expected 8'h%02h, got 8'h%02h",
				$time, name, exp, got);
			stop_with_failure();
		end
	endtask

	task automatic check_word_count(input string name, input int exp, input int got);
		if (got !== exp)
		begin
			$display("Mismatch at time %0t: %s expected %0d, got %0d", $time, name, exp, got);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp)
		begin
			$display("Mismatch at time %0t: %s expected %b, got %b", $time, name, exp, got);
			stop_with_failure();
		end
	endtask

	////////////////////////////////////////
	// Serial receive model
	////////////////////////////////////////

	// Falling edge seen at a negedge, then mid-bit samples
	initial
	begin : serial_receiver
		logic       prev_line;
		uart_byte_t rx_byte;
		prev_line = 1'b1;
		forever
		begin
			@(negedge clk);
			if (reset === 1'b0 && prev_line === 1'b1 && serial_out === 1'b0)
			begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				check_bit("start bit", 1'b0, serial_out);
				for (int b = 0; b < BYTE_W; b++)
				begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					rx_byte[b] = serial_out;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				check_bit("stop bit", 1'b1, serial_out);
				rx_q.push_back(rx_byte);
			end
			prev_line = serial_out;
		end
	end

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	// Quiet line, no strobes
	task automatic idle_gap(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
			check_bit("data_done", 1'b0, data_done);
			check_bit("busy", 1'b0, busy);
			check_bit("serial_out", 1'b1, serial_out);
		end
	endtask

	// Offers a word while idle and checks its four characters
	task automatic send_word(input result_word_t word, input logic junk_pulse,
		input logic hold_next, input result_word_t next_word);
		int           cycles;
		int           junk_at;
		result_word_t junk_word;
		uart_byte_t   b;
		uart_byte_t   exp;
		uart_byte_t   got;
		junk_at   = int'(take_bits(7));
		junk_word = take_bits(32);
		in_data    = word;
		new_result = 1'b1;
		// Model: MSB first, each byte plus the digit offset, mod 256
		for (int k = 0; k < RESULT_BYTES; k++)
		begin
			b = word[31 - k * BYTE_W -: BYTE_W];
			exp_q.push_back(b + ASCII_DIGIT_OFFSET);
		end
		@(posedge clk);
		#1;
		if (hold_next)
			in_data = next_word;
		else
			new_result = 1'b0;
		check_bit("data_done", 1'b0, data_done);
		cycles = 0;
		while (data_done !== 1'b1)
		begin
			check_bit("busy", 1'b1, busy);
			if (junk_pulse && cycles == junk_at)
			begin
				in_data    = junk_word;
				new_result = 1'b1;
			end
			@(posedge clk);
			#1;
			if (!hold_next)
				new_result = 1'b0;
			cycles++;
			if (cycles > DONE_TIMEOUT)
			begin
				$display("Timeout: data_done did not pulse within %0d cycles of word %08h",
					DONE_TIMEOUT, word);
				stop_with_failure();
			end
		end
		check_bit("busy", 1'b0, busy);
		check_word_count("characters per word", RESULT_BYTES, rx_q.size());
		for (int k = 0; k < RESULT_BYTES; k++)
		begin
			got = rx_q.pop_front();
			exp = exp_q.pop_front();
			check_byte("serial character", exp, got);
			last_rx[k] = got;
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin : main_seq
		result_word_t words[NUM_WORDS];
		result_word_t next_word;
		result_word_t digit_word;
		uart_byte_t   digits[RESULT_BYTES];
		uart_byte_t   exp_digit;
		logic [31:0]  r;
		logic         junk;
		logic         hold;
		int           gap;

		reset      = 1'b1;
		new_result = 1'b0;
		in_data    = '0;
		lfsr_state = 32'h3914;

		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		// Line must stay quiet until the first word
		check_bit("serial_out", 1'b1, serial_out);
		check_bit("busy", 1'b0, busy);
		idle_gap(20);
		check_word_count("characters before first word", 0, rx_q.size());

		for (int i = 0; i < NUM_WORDS; i++)
			words[i] = take_bits(32);

		for (int i = 0; i < NUM_WORDS; i++)
		begin
			r    = take_bits(1);
			junk = r[0];
			r    = take_bits(2);
			hold = (i < NUM_WORDS - 1) && (r[1:0] == 2'b00);
			r    = take_bits(3);
			gap  = int'(r[2:0]);
			next_word = '0;
			if (i < NUM_WORDS - 1)
				next_word = words[i + 1];
			send_word(words[i], junk && !hold, hold, next_word);
			if (!hold)
				idle_gap(gap);
		end

		// Digit bytes come out as ASCII digits
		for (int k = 0; k < RESULT_BYTES; k++)
		begin
			r = take_bits(4);
			digits[k] = uart_byte_t'(r[3:0] % 10);
			digit_word[31 - k * BYTE_W -: BYTE_W] = digits[k];
		end
		send_word(digit_word, 1'b0, 1'b0, '0);
		for (int k = 0; k < RESULT_BYTES; k++)
		begin
			exp_digit = "0" + digits[k];
			check_byte("digit character", exp_digit, last_rx[k]);
		end

		idle_gap(60);
		check_word_count("characters after last word", 0, rx_q.size());

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	////////////////////////////////////////
	// Character format
	////////////////////////////////////////

	// 8N1 framing, data sent LSB first
	localparam int UART_DATA_BITS = 8;

	typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

	// Index of the data bit on the line
	typedef logic [$clog2(UART_DATA_BITS)-1:0] uart_bit_idx_t;

	////////////////////////////////////////
	// Transmitter
	////////////////////////////////////////

	typedef enum logic [1:0] {
		tx_idle,
		tx_start_bit,
		tx_data,
		tx_stop
	} uart_tx_state_t;

	// Bit period in clocks unless the top overrides it
	localparam int DEFAULT_CLKS_PER_BIT = 16;

endpackage

`default_nettype wire

// ==== uart_tx.sv ====
`default_nettype none

module uart_tx import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  uart_byte_t tx_byte,
	input  logic       baud_tick,
	output logic       serial_out,
	output logic       baud_restart,
	output logic       tx_done
);

	localparam uart_bit_idx_t LAST_BIT = uart_bit_idx_t'(UART_DATA_BITS - 1);

	uart_tx_state_t state;
	uart_byte_t     shift_reg;
	uart_bit_idx_t  bit_cnt;

	////////////////////////////////////////
	// Strobes to tick gen and framer
	////////////////////////////////////////

	// Start is only honoured while idle
	assign baud_restart = (state == tx_idle) && tx_start;

	// End of the stop bit
	assign tx_done = (state == tx_stop) && baud_tick;

	////////////////////////////////////////
	// Serializer FSM
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state      <= tx_idle;
			bit_cnt    <= '0;
			serial_out <= 1'b1;
		end
		else
		begin
			case (state)
				tx_idle:
				begin
					serial_out <= 1'b1;
					if (tx_start)
					begin
						// Line drops in the next cycle
						serial_out <= 1'b0;
						state      <= tx_start_bit;
					end
				end
				tx_start_bit:
				begin
					if (baud_tick)
					begin
						serial_out <= shift_reg[0];
						bit_cnt    <= '0;
						state      <= tx_data;
					end
				end
				tx_data:
				begin
					if (baud_tick)
					begin
						if (bit_cnt == LAST_BIT)
						begin
							serial_out <= 1'b1;
							state      <= tx_stop;
						end
						else
						begin
							serial_out <= shift_reg[0];
							bit_cnt    <= bit_cnt + 1'b1;
						end
					end
				end
				tx_stop:
				begin
					if (baud_tick)
						state <= tx_idle;
				end
				default:
					state <= tx_idle;
			endcase
		end
	end

	// Payload shifter, LSB goes out first
	always_ff @(posedge clk)
	begin
		if (baud_restart)
			shift_reg <= tx_byte;
		else if (baud_tick && (state == tx_start_bit || state == tx_data))
			shift_reg <= shift_reg >> 1;
	end

endmodule

`default_nettype wire
